/* verilog/csr_pkg.sv */
package csr_pkg;

    // csr numbers are 14 bits wide in the instruction word.
    typedef logic [13:0] csr_num_t;

    localparam csr_num_t csr_crmd   = 14'h0;
    localparam csr_num_t csr_prmd   = 14'h1;
    localparam csr_num_t csr_ecfg   = 14'h4;
    localparam csr_num_t csr_estat  = 14'h5;
    localparam csr_num_t csr_era    = 14'h6;
    localparam csr_num_t csr_eentry = 14'hc;
    localparam csr_num_t csr_save0  = 14'h30;
    localparam csr_num_t csr_save1  = 14'h31;
    localparam csr_num_t csr_save2  = 14'h32;
    localparam csr_num_t csr_save3  = 14'h33;
    localparam csr_num_t csr_tid    = 14'h40;
    localparam csr_num_t csr_tcfg   = 14'h41;
    localparam csr_num_t csr_tval   = 14'h42;
    localparam csr_num_t csr_ticlr  = 14'h44;

    // instruction encodings.
    localparam logic [7:0]  csr_major  = 8'h04;
    localparam logic [31:0] ertn_word  = 32'h0648_3800;
    localparam logic [16:0] syscall_op = 17'h00056;

    // exception codes and interrupt status width.
    localparam logic [5:0] ecode_sys = 6'hb;
    localparam int         is_wid    = 13;

    typedef struct packed {
        logic [7:0] major;
        csr_num_t   num;
        logic [4:0] rj;
        logic [4:0] rd;
    } csr_fmt_t;

    typedef struct packed {
        logic [16:0] opcode;
        logic [14:0] code;
    } sys_fmt_t;

    // one instruction word, seen either as a csr access or as a system op.
    typedef union packed {
        csr_fmt_t csr_fmt;
        sys_fmt_t sys_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        op_rd,
        op_wr,
        op_xchg,
        op_ertn,
        op_syscall,
        op_bad
    } op_kind_e;

    typedef struct packed {
        logic [27:0] rsv;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rsv;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

endpackage

/* verilog/csr_if.sv */
// one decoded op, valid for a single cycle.
interface csr_op_if import csr_pkg::*; ();

    logic        valid;
    op_kind_e    kind;
    csr_num_t    num;
    logic [31:0] wdata;
    logic [31:0] mask;
    logic [31:0] pc;

    modport source (output valid, kind, num, wdata, mask, pc);
    modport sink   (input  valid, kind, num, wdata, mask, pc);

endinterface

// register file access; every request is a one-cycle strobe.
interface csr_access_if import csr_pkg::*; ();

    csr_num_t    addr;
    logic        we;
    logic [31:0] wr_data;
    logic        ertn;
    logic        sys_we;
    logic [31:0] sys_era;
    logic [31:0] rd_data;

    modport master (
        output addr, we, wr_data, ertn, sys_we, sys_era,
        input  rd_data
    );
    modport slave (
        input  addr, we, wr_data, ertn, sys_we, sys_era,
        output rd_data
    );

endinterface

/* verilog/csr_bus_port.sv */
module csr_bus_port import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    input  logic [31:0] result,
    input  logic        result_err,
    input  logic        result_valid,
    output logic        issue,
    output instr_u      instr,
    output logic [31:0] operand,
    output logic [31:0] mask,
    output logic [31:0] pc
);

    logic        pending;
    logic        ready;
    logic        err_q;
    logic [31:0] result_q;
    logic        wr_issue;
    logic        rd_result;
    logic        can_ack;
    logic        take;

    assign wr_issue  = we && (adr == 2'd3);
    assign rd_result = !we && (adr == 2'd3);

    // issue waits for the previous result to be read, the result read waits
    // for the result to arrive.
    always_comb begin
        can_ack = 1'b1;
        if (wr_issue) begin
            can_ack = !pending;
        end else if (rd_result) begin
            can_ack = ready || !pending;
        end
    end

    assign take = cyc && stb && !ack && can_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack      <= 1'b0;
            issue    <= 1'b0;
            pending  <= 1'b0;
            ready    <= 1'b0;
            err_q    <= 1'b0;
            result_q <= '0;
        end else begin
            ack   <= take;
            issue <= take && wr_issue;
            if (take && wr_issue) begin
                pending <= 1'b1;
                ready   <= 1'b0;
            end else if (take && rd_result) begin
                pending <= 1'b0;
                ready   <= 1'b0;
            end else if (result_valid) begin
                ready    <= 1'b1;
                err_q    <= result_err;
                result_q <= result;
            end
        end
    end

    // operand registers.
    always_ff @(posedge clk) begin
        if (take && we) begin
            case (adr)
                2'd0: operand <= dat_w;
                2'd1: mask    <= dat_w;
                2'd2: pc      <= dat_w;
                2'd3: instr   <= instr_u'(dat_w);
            endcase
        end
    end

    always_comb begin
        case (adr)
            2'd0:    dat_r = {31'b0, err_q};
            2'd3:    dat_r = result_q;
            default: dat_r = '0;
        endcase
    end

endmodule

/* verilog/csr_decode.sv */
module csr_decode import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        issue,
    input  instr_u      instr,
    input  logic [31:0] operand,
    input  logic [31:0] mask,
    input  logic [31:0] pc,
    csr_op_if.source    op
);

    op_kind_e kind_d;

    // csr ops by major opcode and rj, system ops by the other view.
    always_comb begin
        if (instr.csr_fmt.major == csr_major) begin
            case (instr.csr_fmt.rj)
                5'd0:    kind_d = op_rd;
                5'd1:    kind_d = op_wr;
                default: kind_d = op_xchg;
            endcase
        end else if (instr == ertn_word) begin
            kind_d = op_ertn;
        end else if (instr.sys_fmt.opcode == syscall_op) begin
            kind_d = op_syscall;
        end else begin
            kind_d = op_bad;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op.kind  <= kind_d;
            op.num   <= instr.csr_fmt.num;
            op.wdata <= operand;
            op.mask  <= mask;
            op.pc    <= pc;
        end
    end

endmodule

/* verilog/csr_execute.sv */
module csr_execute import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    csr_op_if.sink      op,
    csr_access_if.master acc,
    output logic [31:0] result,
    output logic        result_err,
    output logic        result_valid
);

    logic is_bad;

    assign is_bad = (op.kind == op_bad);

    // ertn and syscall read back their target address instead of op.num.
    always_comb begin
        case (op.kind)
            op_ertn:    acc.addr = csr_era;
            op_syscall: acc.addr = csr_eentry;
            default:    acc.addr = op.num;
        endcase
    end

    assign acc.we = op.valid && (op.kind == op_wr || op.kind == op_xchg);

    // xchg keeps the old bits where the mask is clear.
    assign acc.wr_data = (op.kind == op_xchg) ?
                         ((op.wdata & op.mask) | (acc.rd_data & ~op.mask)) : op.wdata;

    assign acc.ertn    = op.valid && (op.kind == op_ertn);
    assign acc.sys_we  = op.valid && (op.kind == op_syscall);
    assign acc.sys_era = op.pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_err   <= 1'b0;
        end else begin
            result_valid <= op.valid;
            if (op.valid) begin
                result_err <= is_bad;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            result <= is_bad ? 32'b0 : acc.rd_data;
        end
    end

endmodule

/* verilog/csr_regfile.sv */
module csr_regfile import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    csr_access_if.slave acc,
    input  logic [7:0]  hwi,
    input  logic        ti,
    output logic        ti_clr,
    output logic        tcfg_we,
    output logic [31:0] tcfg_data,
    input  logic [31:0] tval,
    input  logic [31:0] tcfg,
    output logic        irq
);

    crmd_t              crmd;
    prmd_t              prmd;
    logic [is_wid-1:0]  lie;
    logic [1:0]         swi;
    logic [5:0]         ecode;
    logic [31:0]        era;
    logic [25:0]        eentry;
    logic [31:0]        save [4];
    logic [31:0]        tid;
    logic [is_wid-1:0]  is_bits;
    logic [31:0]        estat;

    // interrupt status: timer at 11, hardware lines at 9:2, software at 1:0.
    assign is_bits = {1'b0, ti, 1'b0, hwi, swi};
    assign estat   = {1'b0, 9'b0, ecode, 3'b0, is_bits};

    assign irq = crmd.ie && |(is_bits & lie);

    // timer registers live in csr_timer.
    assign tcfg_we   = acc.we && (acc.addr == csr_tcfg);
    assign tcfg_data = acc.wr_data;
    assign ti_clr    = acc.we && (acc.addr == csr_ticlr) && acc.wr_data[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd   <= '{rsv: '0, da: 1'b1, ie: 1'b0, plv: 2'b00};
            prmd   <= '0;
            lie    <= '0;
            swi    <= '0;
            ecode  <= '0;
            era    <= '0;
            eentry <= '0;
            tid    <= '0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else if (acc.sys_we) begin
            // exception entry.
            prmd.pplv <= crmd.plv;
            prmd.pie  <= crmd.ie;
            crmd.plv  <= 2'b00;
            crmd.ie   <= 1'b0;
            ecode     <= ecode_sys;
            era       <= acc.sys_era;
        end else if (acc.ertn) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (acc.we) begin
            case (acc.addr)
                csr_crmd:   crmd[8:0] <= acc.wr_data[8:0];
                csr_prmd:   prmd[2:0] <= acc.wr_data[2:0];
                csr_ecfg:   lie <= acc.wr_data[is_wid-1:0];
                // only the software interrupt bits are writable.
                csr_estat:  swi <= acc.wr_data[1:0];
                csr_era:    era <= acc.wr_data;
                csr_eentry: eentry <= acc.wr_data[31:6];
                csr_save0, csr_save1, csr_save2, csr_save3: begin
                    save[acc.addr[1:0]] <= acc.wr_data;
                end
                csr_tid:    tid <= acc.wr_data;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (acc.addr)
            csr_crmd:   acc.rd_data = crmd;
            csr_prmd:   acc.rd_data = prmd;
            csr_ecfg:   acc.rd_data = {{(32 - is_wid){1'b0}}, lie};
            csr_estat:  acc.rd_data = estat;
            csr_era:    acc.rd_data = era;
            csr_eentry: acc.rd_data = {eentry, 6'b0};
            csr_save0, csr_save1, csr_save2, csr_save3: begin
                acc.rd_data = save[acc.addr[1:0]];
            end
            csr_tid:    acc.rd_data = tid;
            csr_tcfg:   acc.rd_data = tcfg;
            csr_tval:   acc.rd_data = tval;
            // ticlr is write-one and reads as zero.
            default:    acc.rd_data = '0;
        endcase
    end

endmodule

/* verilog/csr_timer.sv */
module csr_timer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tcfg_we,
    input  logic [31:0] tcfg_data,
    input  logic        ti_clr,
    output logic [31:0] tval,
    output logic [31:0] tcfg,
    output logic        ti
);

    logic en;
    logic flag;
    logic expire;

    assign expire = en && (tval == 32'b0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en   <= 1'b0;
            flag <= 1'b0;
            tcfg <= '0;
            tval <= '0;
        end else begin
            if (tcfg_we) begin
                // initval sits in bits 31:2, so the count is initval times 4.
                tcfg <= tcfg_data;
                en   <= tcfg_data[0];
                tval <= {tcfg_data[31:2], 2'b00};
            end else if (expire) begin
                en   <= tcfg[1];
                tval <= tcfg[1] ? {tcfg[31:2], 2'b00} : 32'hffff_ffff;
            end else if (en) begin
                tval <= tval - 32'd1;
            end
            if (ti_clr) begin
                flag <= 1'b0;
            end else if (expire) begin
                flag <= 1'b1;
            end
        end
    end

    assign ti = flag || expire;

endmodule

/* verilog/csr_unit.sv */
module csr_unit import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    input  logic [7:0]  hwi,
    output logic        irq
);

    logic [31:0] result;
    logic        result_err;
    logic        result_valid;
    logic        issue;
    instr_u      instr;
    logic [31:0] operand;
    logic [31:0] mask;
    logic [31:0] pc;
    logic        ti;
    logic        ti_clr;
    logic        tcfg_we;
    logic [31:0] tcfg_data;
    logic [31:0] tval;
    logic [31:0] tcfg;

    csr_op_if     op_bus ();
    csr_access_if acc_bus ();

    csr_bus_port i_bus_port (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .result, .result_err, .result_valid,
        .issue, .instr, .operand, .mask, .pc
    );

    csr_decode i_decode (
        .clk, .rst_n, .issue, .instr, .operand, .mask, .pc,
        .op (op_bus.source)
    );

    csr_execute i_execute (
        .clk, .rst_n,
        .op  (op_bus.sink),
        .acc (acc_bus.master),
        .result, .result_err, .result_valid
    );

    csr_regfile i_regfile (
        .clk, .rst_n,
        .acc (acc_bus.slave),
        .hwi, .ti, .ti_clr, .tcfg_we, .tcfg_data, .tval, .tcfg,
        .irq
    );

    csr_timer i_timer (
        .clk, .rst_n, .tcfg_we, .tcfg_data, .ti_clr, .tval, .tcfg, .ti
    );

endmodule

/* test/csr_unit_chk.sv */
module csr_unit_chk (
    input logic clk,
    input logic rst_n,
    input logic stb,
    input logic ack,
    input logic irq,
    input logic ie
);

    // failure count, read by the testbench at the end of the run.
    int fails = 0;

    ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n) ack |-> stb)
        else begin
            $error("ack is high while stb is low");
            fails++;
        end

    // a slave ack is a single-cycle pulse.
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
        else begin
            $error("ack stayed high for more than one cycle");
            fails++;
        end

    irq_needs_ie: assert property (@(posedge clk) disable iff (!rst_n) irq |-> ie)
        else begin
            $error("irq is high while crmd.ie is low");
            fails++;
        end

endmodule

bind csr_bus_port csr_unit_chk i_bus_chk (
    .clk(clk), .rst_n(rst_n), .stb(cyc && stb), .ack(ack), .irq(1'b0), .ie(1'b1)
);

bind csr_regfile csr_unit_chk i_regfile_chk (
    .clk(clk), .rst_n(rst_n), .stb(1'b1), .ack(1'b0), .irq(irq), .ie(crmd.ie)
);

/* test/tb_csr_unit.sv */
module tb_csr_unit import csr_pkg::*; ();

    typedef enum logic [1:0] {cmp_exact, cmp_nonzero, cmp_poll} cmp_e;

    typedef struct packed {
        logic [2:0]  test;
        logic [31:0] instr;
        logic [31:0] operand;
        logic [31:0] mask;
        logic [31:0] pc;
        logic [7:0]  hwi;
        cmp_e        cmp;
        logic [31:0] exp_res;
        logic        exp_err;
        logic        exp_irq;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic [7:0]  hwi;
    logic        irq;

    entry_t      tbl [$];
    logic        tbl_ready = 1'b0;
    logic [15:0] lfsr;
    int          test_errs;
    int          tests_ok;
    int          tests_bad;

    // reference state of the csr file.
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [12:0] m_lie;
    logic [1:0]  m_swi;
    logic [5:0]  m_ecode;
    logic [31:0] m_era;
    logic [31:0] m_eentry;
    logic [31:0] m_save [4];
    logic [31:0] m_tid;
    logic [31:0] m_tcfg;
    logic        m_ti;

    csr_unit i_csr_unit (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack, .hwi, .irq
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit.
    task automatic rand_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_next(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    function automatic logic [31:0] csr_word(input csr_num_t num, input logic [4:0] rj);
        return {csr_major, num, rj, 5'd4};
    endfunction

    function automatic logic [31:0] csr_value(input csr_num_t num, input logic [7:0] h);
        case (num)
            csr_crmd:   return m_crmd;
            csr_prmd:   return m_prmd;
            csr_ecfg:   return {19'b0, m_lie};
            csr_estat:  return {10'b0, m_ecode, 4'b0, m_ti, 1'b0, h, m_swi};
            csr_era:    return m_era;
            csr_eentry: return m_eentry;
            csr_save0, csr_save1, csr_save2, csr_save3: return m_save[num[1:0]];
            csr_tid:    return m_tid;
            csr_tcfg:   return m_tcfg;
            default:    return 32'b0;
        endcase
    endfunction

    task automatic store_csr(input csr_num_t num, input logic [31:0] d);
        case (num)
            csr_crmd:   m_crmd = (m_crmd & ~32'h1ff) | (d & 32'h1ff);
            csr_prmd:   m_prmd = (m_prmd & ~32'h7) | (d & 32'h7);
            csr_ecfg:   m_lie = d[12:0];
            csr_estat:  m_swi = d[1:0];
            csr_era:    m_era = d;
            csr_eentry: m_eentry = d & 32'hffff_ffc0;
            csr_save0, csr_save1, csr_save2, csr_save3: m_save[num[1:0]] = d;
            csr_tid:    m_tid = d;
            csr_tcfg:   m_tcfg = d;
            csr_ticlr:  m_ti = d[0] ? 1'b0 : m_ti;
            default: ;
        endcase
    endtask

    function automatic logic expected_irq(input logic [7:0] h);
        logic [12:0] is_bits;
        is_bits = {1'b0, m_ti, 1'b0, h, m_swi};
        return m_crmd[2] && |(is_bits & m_lie);
    endfunction

    // runs the reference model over one op and queues it with its expected values.
    task automatic add_op(input logic [2:0] test, input logic [31:0] instr,
                          input logic [31:0] operand, input logic [31:0] mask,
                          input logic [31:0] pc, input logic [7:0] h, input cmp_e cmp);
        entry_t      e;
        logic [31:0] old;
        csr_num_t    num;
        e = '{test: test, instr: instr, operand: operand, mask: mask, pc: pc,
              hwi: h, cmp: cmp, exp_res: 32'b0, exp_err: 1'b0, exp_irq: 1'b0};
        num = instr[23:10];
        if (cmp == cmp_poll) begin
            m_ti = 1'b1;
        end
        if (instr[31:24] == csr_major) begin
            old = csr_value(num, h);
            e.exp_res = old;
            if (instr[9:5] == 5'd1) begin
                store_csr(num, operand);
            end else if (instr[9:5] != 5'd0) begin
                store_csr(num, (operand & mask) | (old & ~mask));
            end
        end else if (instr == ertn_word) begin
            e.exp_res = m_era;
            m_crmd[2:0] = m_prmd[2:0];
        end else if (instr[31:15] == syscall_op) begin
            e.exp_res = m_eentry;
            m_prmd[2:0] = m_crmd[2:0];
            m_crmd[2:0] = 3'b000;
            m_ecode = ecode_sys;
            m_era = pc;
        end else begin
            e.exp_err = 1'b1;
        end
        e.exp_irq = expected_irq(h);
        tbl.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] v;
        logic [31:0] m;
        csr_num_t    plain_regs [6];
        csr_num_t    xchg_regs [4];
        plain_regs = '{csr_save0, csr_save1, csr_save2, csr_save3, csr_era, csr_tid};
        xchg_regs = '{csr_crmd, csr_prmd, csr_eentry, csr_save0};
        lfsr = 16'd5580;
        m_crmd = 32'h8;
        m_prmd = '0;
        m_lie = '0;
        m_swi = '0;
        m_ecode = '0;
        m_era = '0;
        m_eentry = '0;
        m_tid = '0;
        m_tcfg = '0;
        m_ti = 1'b0;
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end
        for (int i = 0; i < 6; i++) begin
            add_op(1, csr_word(plain_regs[i], 5'd1), 32'ha5c3_0010 + i, 0, 0, 0, cmp_exact);
            add_op(1, csr_word(plain_regs[i], 5'd0), 0, 0, 0, 0, cmp_exact);
        end
        add_op(1, csr_word(14'h100, 5'd1), 32'hdead_beef, 0, 0, 0, cmp_exact);
        add_op(1, csr_word(14'h100, 5'd0), 0, 0, 0, 0, cmp_exact);
        for (int i = 0; i < 4; i++) begin
            rand_word(v);
            rand_word(m);
            add_op(2, csr_word(xchg_regs[i], 5'd7), v, m, 0, 0, cmp_exact);
            add_op(2, csr_word(xchg_regs[i], 5'd0), 0, 0, 0, 0, cmp_exact);
        end
        // plv 3 with ie set, so ertn has something to restore.
        add_op(3, csr_word(csr_eentry, 5'd1), 32'h1c00_0100, 0, 0, 0, cmp_exact);
        add_op(3, csr_word(csr_crmd, 5'd1), 32'h0000_000f, 0, 0, 0, cmp_exact);
        add_op(3, {syscall_op, 15'd0}, 0, 0, 32'h1c00_0480, 0, cmp_exact);
        add_op(3, csr_word(csr_estat, 5'd0), 0, 0, 0, 0, cmp_exact);
        add_op(3, csr_word(csr_era, 5'd0), 0, 0, 0, 0, cmp_exact);
        add_op(3, csr_word(csr_crmd, 5'd0), 0, 0, 0, 0, cmp_exact);
        add_op(3, ertn_word, 0, 0, 0, 0, cmp_exact);
        add_op(3, csr_word(csr_crmd, 5'd0), 0, 0, 0, 0, cmp_exact);
        add_op(4, csr_word(csr_ecfg, 5'd1), 32'h3, 0, 0, 0, cmp_exact);
        add_op(4, csr_word(csr_estat, 5'd1), 32'h1, 0, 0, 0, cmp_exact);
        add_op(4, csr_word(csr_estat, 5'd1), 32'h0, 0, 0, 0, cmp_exact);
        add_op(4, csr_word(csr_ecfg, 5'd1), 32'h3fc, 0, 0, 0, cmp_exact);
        add_op(4, csr_word(csr_estat, 5'd0), 0, 0, 0, 8'h10, cmp_exact);
        add_op(4, csr_word(csr_crmd, 5'd1), 32'h8, 0, 0, 8'h10, cmp_exact);
        // initval 8 in one-shot mode.
        add_op(5, csr_word(csr_tcfg, 5'd1), 32'h21, 0, 0, 0, cmp_exact);
        add_op(5, csr_word(csr_tval, 5'd0), 0, 0, 0, 0, cmp_nonzero);
        add_op(5, csr_word(csr_estat, 5'd0), 0, 0, 0, 0, cmp_poll);
        add_op(5, csr_word(csr_ticlr, 5'd1), 32'h1, 0, 0, 0, cmp_exact);
        add_op(5, csr_word(csr_estat, 5'd0), 0, 0, 0, 0, cmp_exact);
        add_op(6, 32'hffff_ffff, 0, 0, 0, 0, cmp_exact);
        add_op(6, csr_word(csr_save0, 5'd0), 0, 0, 0, 0, cmp_exact);
    endtask

    // starts and ends one edge plus 1 after the clock, stb held through the ack edge.
    task automatic bus_cycle(input logic wr, input logic [1:0] a, input logic [31:0] d,
                             output logic [31:0] q);
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        adr = a;
        dat_w = d;
        @(posedge clk);
        #1;
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        q = dat_r;
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic run_op(input entry_t e, output logic [31:0] res, output logic [31:0] status);
        logic [31:0] unused;
        bus_cycle(1'b1, 2'd0, e.operand, unused);
        bus_cycle(1'b1, 2'd1, e.mask, unused);
        bus_cycle(1'b1, 2'd2, e.pc, unused);
        bus_cycle(1'b1, 2'd3, e.instr, unused);
        bus_cycle(1'b0, 2'd3, 32'b0, res);
        bus_cycle(1'b0, 2'd0, 32'b0, status);
    endtask

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "csrwr and csrrd";
            3'd2:    return "csrxchg with lfsr masks";
            3'd3:    return "syscall and ertn";
            3'd4:    return "interrupt request";
            3'd5:    return "interval timer";
            default: return "undefined instruction";
        endcase
    endfunction

    initial begin
        entry_t      e;
        logic [31:0] res;
        logic [31:0] status;
        int          tries;
        int          asserts;
        clk = 1'b0;
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = 2'd0;
        dat_w = 32'b0;
        hwi = 8'h00;
        test_errs = 0;
        tests_ok = 0;
        tests_bad = 0;
        build_table();
        tbl_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            hwi = e.hwi;
            run_op(e, res, status);
            tries = 0;
            while (e.cmp == cmp_poll && !res[11] && tries < 20) begin
                run_op(e, res, status);
                tries++;
            end
            if (e.cmp == cmp_poll && !res[11]) begin
                $display("entry %0d: timer bit 11 never came up in estat", i);
                test_errs++;
            end
            if (e.cmp == cmp_nonzero) begin
                if (res == 32'b0) begin
                    $display("entry %0d: tval read zero right after loading tcfg", i);
                    test_errs++;
                end
            end else if (res !== e.exp_res) begin
                $display("Mismatch entry %0d result: got %h expected %h", i, res, e.exp_res);
                test_errs++;
            end
            if (status[0] !== e.exp_err) begin
                $display("Mismatch entry %0d status: got %h expected %h", i, status[0], e.exp_err);
                test_errs++;
            end
            if (irq !== e.exp_irq) begin
                $display("Mismatch entry %0d irq: got %h expected %h", i, irq, e.exp_irq);
                test_errs++;
            end
            if (i == tbl.size() - 1 || tbl[i + 1].test != e.test) begin
                if (test_errs == 0) begin
                    $display("test %0d %s: ok", e.test, test_name(e.test));
                    tests_ok++;
                end else begin
                    $display("test %0d %s: %0d errors", e.test, test_name(e.test), test_errs);
                    tests_bad++;
                end
                test_errs = 0;
            end
        end
        asserts = i_csr_unit.i_bus_port.i_bus_chk.fails + i_csr_unit.i_regfile.i_regfile_chk.fails;
        if (asserts != 0) begin
            $display("%0d assertion failures in the bound checkers", asserts);
        end
        $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && asserts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // 200 clocks per table entry.
    initial begin
        wait (tbl_ready);
        #(tbl.size() * 200 * 20);
        $display("timeout, the run did not finish within %0d clocks", tbl.size() * 200);
        $display("tests failed");
        $finish;
    end

endmodule

/* compile.f */
verilog/csr_pkg.sv
verilog/csr_if.sv
verilog/csr_bus_port.sv
verilog/csr_decode.sv
verilog/csr_execute.sv
verilog/csr_regfile.sv
verilog/csr_timer.sv
verilog/csr_unit.sv
test/csr_unit_chk.sv
test/tb_csr_unit.sv
